/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    // ----------------------------------------------------------------------
    // Widths.
    // ----------------------------------------------------------------------
    localparam int xlen       = 32;
    localparam int rob_id_w   = 5;
    localparam int phy_reg_w  = 6;
    localparam int arch_reg_w = 5;
    localparam int alu_op_w   = 4;
    localparam int fifo_depth = 4;  // Result queue entries.

    // ----------------------------------------------------------------------
    // ALU micro-op encodings.
    // ----------------------------------------------------------------------
    localparam logic [alu_op_w-1:0] alu_add  = 4'd0;
    localparam logic [alu_op_w-1:0] alu_sub  = 4'd1;
    localparam logic [alu_op_w-1:0] alu_sll  = 4'd2;
    localparam logic [alu_op_w-1:0] alu_slt  = 4'd3;
    localparam logic [alu_op_w-1:0] alu_sltu = 4'd4;
    localparam logic [alu_op_w-1:0] alu_xor  = 4'd5;
    localparam logic [alu_op_w-1:0] alu_srl  = 4'd6;
    localparam logic [alu_op_w-1:0] alu_sra  = 4'd7;
    localparam logic [alu_op_w-1:0] alu_or   = 4'd8;
    localparam logic [alu_op_w-1:0] alu_and  = 4'd9;

    // Operand selectors.
    localparam logic [1:0] op1_rs1  = 2'd0;
    localparam logic [1:0] op1_zero = 2'd1;
    localparam logic [1:0] op1_pc   = 2'd2;

    localparam logic [1:0] op2_rs2  = 2'd0;
    localparam logic [1:0] op2_zero = 2'd1;
    localparam logic [1:0] op2_imm  = 2'd2;

    // Major opcodes, RV32I.
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // One instruction word, seen in R, I or U format.
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [4:0]            rs2;
            logic [4:0]            rs1;
            logic [2:0]            funct3;
            logic [arch_reg_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [4:0]            rs1;
            logic [2:0]            funct3;
            logic [arch_reg_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
        struct packed {
            logic [19:0]           imm20;
            logic [arch_reg_w-1:0] rd;
            logic [6:0]            opcode;
        } u;
    } rv_instr_u;

endpackage

`default_nettype wire

/* src/int_decode_issue.sv */
`timescale 1ns/1ns
`default_nettype none

module int_decode_issue (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               disp_valid,
    output logic                               disp_ready,
    input  cpu_pkg::rv_instr_u                 disp_instr,
    input  logic [cpu_pkg::xlen-1:0]           disp_pc,
    input  logic [cpu_pkg::rob_id_w-1:0]       disp_rob_id,
    input  logic [cpu_pkg::phy_reg_w-1:0]      disp_rd_phy,
    input  logic [cpu_pkg::xlen-1:0]           disp_rs1_value,
    input  logic [cpu_pkg::xlen-1:0]           disp_rs2_value,
    output logic                               iss_valid,
    input  logic                               iss_ready,
    output logic [cpu_pkg::alu_op_w-1:0]       iss_op,
    output logic [1:0]                         iss_op1_sel,
    output logic [1:0]                         iss_op2_sel,
    output logic [cpu_pkg::xlen-1:0]           iss_imm,
    output logic [cpu_pkg::xlen-1:0]           iss_pc,
    output logic [cpu_pkg::xlen-1:0]           iss_rs1_value,
    output logic [cpu_pkg::xlen-1:0]           iss_rs2_value,
    output logic [cpu_pkg::rob_id_w-1:0]       iss_rob_id,
    output logic [cpu_pkg::phy_reg_w-1:0]      iss_rd_phy,
    output logic [cpu_pkg::arch_reg_w-1:0]     iss_rd_arch
);
    import cpu_pkg::*;

    logic [alu_op_w-1:0] dec_op;
    logic [1:0]          dec_op1_sel;
    logic [1:0]          dec_op2_sel;
    logic [xlen-1:0]     dec_imm;
    logic                is_shift;

    // funct3 to ALU op; alt is instr[30].
    function automatic logic [alu_op_w-1:0] f3_to_op(input logic [2:0] f3, input logic sub_ok,
                                                      input logic alt);
        case (f3)
            3'b000:  return (sub_ok && alt) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign is_shift = (disp_instr.i.funct3 == 3'b001) || (disp_instr.i.funct3 == 3'b101);

    // ----------------------------------------------------------------------
    // Decode.
    // ----------------------------------------------------------------------
    always_comb begin
        dec_op      = alu_add;
        dec_op1_sel = op1_zero;
        dec_op2_sel = op2_zero;  // Unknown opcodes produce zero.
        dec_imm     = '0;
        case (disp_instr.r.opcode)
            opc_op: begin
                dec_op      = f3_to_op(disp_instr.r.funct3, 1'b1, disp_instr.r.funct7[5]);
                dec_op1_sel = op1_rs1;
                dec_op2_sel = op2_rs2;
            end
            opc_op_imm: begin
                dec_op      = f3_to_op(disp_instr.i.funct3, 1'b0, disp_instr.r.funct7[5]);
                dec_op1_sel = op1_rs1;
                dec_op2_sel = op2_imm;
                if (is_shift) begin
                    dec_imm = {{(xlen-5){1'b0}}, disp_instr.r.rs2};  // Shamt only.
                end else begin
                    dec_imm = {{(xlen-12){disp_instr.i.imm12[11]}}, disp_instr.i.imm12};
                end
            end
            opc_lui, opc_auipc: begin
                dec_op1_sel = (disp_instr.u.opcode == opc_auipc) ? op1_pc : op1_zero;
                dec_op2_sel = op2_imm;
                dec_imm     = {disp_instr.u.imm20, 12'b0};
            end
            default: ;
        endcase
    end

    // ----------------------------------------------------------------------
    // Issue slot.
    // ----------------------------------------------------------------------
    assign disp_ready = !iss_valid || iss_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else if (disp_ready) begin
            iss_valid <= disp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid && disp_ready) begin
            iss_op        <= dec_op;
            iss_op1_sel   <= dec_op1_sel;
            iss_op2_sel   <= dec_op2_sel;
            iss_imm       <= dec_imm;
            iss_pc        <= disp_pc;
            iss_rs1_value <= disp_rs1_value;
            iss_rs2_value <= disp_rs2_value;
            iss_rob_id    <= disp_rob_id;
            iss_rd_phy    <= disp_rd_phy;
            iss_rd_arch   <= disp_instr.r.rd;
        end
    end

endmodule

`default_nettype wire

/* src/fu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module fu_alu (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               iss_valid,
    output logic                               iss_ready,
    input  logic [cpu_pkg::alu_op_w-1:0]       iss_op,
    input  logic [1:0]                         iss_op1_sel,
    input  logic [1:0]                         iss_op2_sel,
    input  logic [cpu_pkg::xlen-1:0]           iss_imm,
    input  logic [cpu_pkg::xlen-1:0]           iss_pc,
    input  logic [cpu_pkg::xlen-1:0]           iss_rs1_value,
    input  logic [cpu_pkg::xlen-1:0]           iss_rs2_value,
    input  logic [cpu_pkg::rob_id_w-1:0]       iss_rob_id,
    input  logic [cpu_pkg::phy_reg_w-1:0]      iss_rd_phy,
    input  logic [cpu_pkg::arch_reg_w-1:0]     iss_rd_arch,
    output logic                               res_valid,
    input  logic                               res_ready,
    output logic [cpu_pkg::rob_id_w-1:0]       res_rob_id,
    output logic [cpu_pkg::phy_reg_w-1:0]      res_rd_phy,
    output logic [cpu_pkg::arch_reg_w-1:0]     res_rd_arch,
    output logic [cpu_pkg::xlen-1:0]           res_value
);
    import cpu_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] alu_out;
    logic [4:0]      shamt;

    // ----------------------------------------------------------------------
    // Operand select.
    // ----------------------------------------------------------------------
    always_comb begin
        case (iss_op1_sel)
            op1_rs1: a = iss_rs1_value;
            op1_pc:  a = iss_pc;
            default: a = '0;  // op1_zero.
        endcase
        case (iss_op2_sel)
            op2_rs2: b = iss_rs2_value;
            op2_imm: b = iss_imm;
            default: b = '0;
        endcase
    end

    assign shamt = b[4:0];

    // ----------------------------------------------------------------------
    // Execute.
    // ----------------------------------------------------------------------
    always_comb begin
        case (iss_op)
            alu_add:  alu_out = a + b;
            alu_sub:  alu_out = a - b;
            alu_sll:  alu_out = a << shamt;
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  alu_out = a ^ b;
            alu_srl:  alu_out = a >> shamt;
            alu_sra:  alu_out = $unsigned($signed(a) >>> shamt);
            alu_or:   alu_out = a | b;
            alu_and:  alu_out = a & b;
            default:  alu_out = '0;
        endcase
    end

    // Result register; holds until the queue takes it.
    assign iss_ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (iss_ready) begin
            res_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid && iss_ready) begin
            res_rob_id  <= iss_rob_id;
            res_rd_phy  <= iss_rd_phy;
            res_rd_arch <= iss_rd_arch;
            res_value   <= alu_out;
        end
    end

endmodule

`default_nettype wire

/* src/cdb_result_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module cdb_result_fifo (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               res_valid,
    output logic                               res_ready,
    input  logic [cpu_pkg::rob_id_w-1:0]       res_rob_id,
    input  logic [cpu_pkg::phy_reg_w-1:0]      res_rd_phy,
    input  logic [cpu_pkg::arch_reg_w-1:0]     res_rd_arch,
    input  logic [cpu_pkg::xlen-1:0]           res_value,
    output logic                               head_valid,
    input  logic                               head_pop,
    output logic [cpu_pkg::rob_id_w-1:0]       head_rob_id,
    output logic [cpu_pkg::phy_reg_w-1:0]      head_rd_phy,
    output logic [cpu_pkg::arch_reg_w-1:0]     head_rd_arch,
    output logic [cpu_pkg::xlen-1:0]           head_value
);
    import cpu_pkg::*;

    localparam int ptr_w   = $clog2(fifo_depth);
    localparam int cnt_w   = $clog2(fifo_depth + 1);
    localparam int entry_w = rob_id_w + phy_reg_w + arch_reg_w + xlen;

    logic [entry_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               push;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(fifo_depth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign res_ready  = (count != cnt_w'(fifo_depth));
    assign head_valid = (count != '0);
    assign push       = res_valid && res_ready;
    assign {head_rob_id, head_rd_phy, head_rd_arch, head_value} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {res_rob_id, res_rd_phy, res_rd_arch, res_value};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (head_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, head_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/cdb_broadcast.sv */
`timescale 1ns/1ns
`default_nettype none

module cdb_broadcast (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               cdb_grant,
    input  logic                               head_valid,
    output logic                               head_pop,
    input  logic [cpu_pkg::rob_id_w-1:0]       head_rob_id,
    input  logic [cpu_pkg::phy_reg_w-1:0]      head_rd_phy,
    input  logic [cpu_pkg::arch_reg_w-1:0]     head_rd_arch,
    input  logic [cpu_pkg::xlen-1:0]           head_value,
    output logic                               cdb_valid,
    output logic [cpu_pkg::rob_id_w-1:0]       cdb_rob_id,
    output logic [cpu_pkg::phy_reg_w-1:0]      cdb_rd_phy,
    output logic [cpu_pkg::arch_reg_w-1:0]     cdb_rd_arch,
    output logic [cpu_pkg::xlen-1:0]           cdb_value
);

    assign head_pop = cdb_grant && head_valid;

    // One bus cycle per popped entry.
    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= head_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (head_pop) begin
            cdb_rob_id  <= head_rob_id;
            cdb_rd_phy  <= head_rd_phy;
            cdb_rd_arch <= head_rd_arch;
            cdb_value   <= head_value;
        end
    end

endmodule

`default_nettype wire

/* src/int_exec_cluster.sv */
`timescale 1ns/1ns
`default_nettype none

module int_exec_cluster (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               disp_valid,
    output logic                               disp_ready,
    input  cpu_pkg::rv_instr_u                 disp_instr,
    input  logic [cpu_pkg::xlen-1:0]           disp_pc,
    input  logic [cpu_pkg::rob_id_w-1:0]       disp_rob_id,
    input  logic [cpu_pkg::phy_reg_w-1:0]      disp_rd_phy,
    input  logic [cpu_pkg::xlen-1:0]           disp_rs1_value,
    input  logic [cpu_pkg::xlen-1:0]           disp_rs2_value,
    input  logic                               cdb_grant,
    output logic                               cdb_valid,
    output logic [cpu_pkg::rob_id_w-1:0]       cdb_rob_id,
    output logic [cpu_pkg::phy_reg_w-1:0]      cdb_rd_phy,
    output logic [cpu_pkg::arch_reg_w-1:0]     cdb_rd_arch,
    output logic [cpu_pkg::xlen-1:0]           cdb_value
);
    import cpu_pkg::*;

    // ----------------------------------------------------------------------
    // Issue path.
    // ----------------------------------------------------------------------
    logic                  iss_valid;
    logic                  iss_ready;
    logic [alu_op_w-1:0]   iss_op;
    logic [1:0]            iss_op1_sel;
    logic [1:0]            iss_op2_sel;
    logic [xlen-1:0]       iss_imm;
    logic [xlen-1:0]       iss_pc;
    logic [xlen-1:0]       iss_rs1_value;
    logic [xlen-1:0]       iss_rs2_value;
    logic [rob_id_w-1:0]   iss_rob_id;
    logic [phy_reg_w-1:0]  iss_rd_phy;
    logic [arch_reg_w-1:0] iss_rd_arch;

    // Result path and queue head.
    logic                  res_valid;
    logic                  res_ready;
    logic [rob_id_w-1:0]   res_rob_id;
    logic [phy_reg_w-1:0]  res_rd_phy;
    logic [arch_reg_w-1:0] res_rd_arch;
    logic [xlen-1:0]       res_value;

    logic                  head_valid;
    logic                  head_pop;
    logic [rob_id_w-1:0]   head_rob_id;
    logic [phy_reg_w-1:0]  head_rd_phy;
    logic [arch_reg_w-1:0] head_rd_arch;
    logic [xlen-1:0]       head_value;

    int_decode_issue u_decode (.*);
    fu_alu           u_alu    (.*);
    cdb_result_fifo  u_fifo   (.*);
    cdb_broadcast    u_cdb    (.*);

endmodule

`default_nettype wire

/* sim/int_exec_cluster_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module int_exec_cluster_assertions (
    input logic                               clk,
    input logic                               rst,
    input logic                               disp_valid,
    input logic                               disp_ready,
    input cpu_pkg::rv_instr_u                 disp_instr,
    input logic [cpu_pkg::xlen-1:0]           disp_pc,
    input logic [cpu_pkg::rob_id_w-1:0]       disp_rob_id,
    input logic [cpu_pkg::phy_reg_w-1:0]      disp_rd_phy,
    input logic [cpu_pkg::xlen-1:0]           disp_rs1_value,
    input logic [cpu_pkg::xlen-1:0]           disp_rs2_value,
    input logic                               cdb_grant,
    input logic                               cdb_valid,
    input logic                               res_valid,
    input logic                               res_ready
);
    import cpu_pkg::*;

    // Dispatch payload holds while stalled.
    assert property (@(posedge clk) disable iff (rst)
        (disp_valid && !disp_ready) |=> $stable({disp_instr, disp_pc, disp_rob_id,
                                                 disp_rd_phy, disp_rs1_value, disp_rs2_value}))
    else $error("dispatch payload changed while disp_ready was low");

    assert property (@(posedge clk) disable iff (rst) cdb_valid |-> $past(cdb_grant))
    else $error("cdb_valid without a grant on the previous cycle");

    assert property (@(posedge clk) $fell(rst) |-> (disp_ready && !cdb_valid))
    else $error("cluster not idle in the first cycle after reset");

    // A stalled result gets into the queue once the bus is granted.
    assert property (@(posedge clk) disable iff (rst)
        (res_valid && !res_ready && cdb_grant) |-> ##[1:fifo_depth] res_ready)
    else $error("result queue stayed full under grant");

endmodule

bind int_exec_cluster int_exec_cluster_assertions u_assertions (.*);

`default_nettype wire

/* sim/tb_int_exec_cluster.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_int_exec_cluster;
    import cpu_pkg::*;

    localparam int n_rows = 24;

    logic                  clk;
    logic                  rst;
    logic                  disp_valid;
    logic                  disp_ready;
    rv_instr_u             disp_instr;
    logic [xlen-1:0]       disp_pc;
    logic [rob_id_w-1:0]   disp_rob_id;
    logic [phy_reg_w-1:0]  disp_rd_phy;
    logic [xlen-1:0]       disp_rs1_value;
    logic [xlen-1:0]       disp_rs2_value;
    logic                  cdb_grant;
    logic                  cdb_valid;
    logic [rob_id_w-1:0]   cdb_rob_id;
    logic [phy_reg_w-1:0]  cdb_rd_phy;
    logic [arch_reg_w-1:0] cdb_rd_arch;
    logic [xlen-1:0]       cdb_value;

    // Stimulus table.
    rv_instr_u       tbl_instr [n_rows];
    logic [xlen-1:0] tbl_pc    [n_rows];
    logic [xlen-1:0] tbl_rs1   [n_rows];
    logic [xlen-1:0] tbl_rs2   [n_rows];
    logic [xlen-1:0] tbl_exp   [n_rows];
    int              tbl_hold  [n_rows];
    int              nrow = 0;
    logic [31:0]     rng = 32'd88497;

    // Scoreboard.
    logic [47:0]           expq [$];
    logic [xlen-1:0]       cur_exp;
    logic [rob_id_w-1:0]   e_rob;
    logic [phy_reg_w-1:0]  e_phy;
    logic [arch_reg_w-1:0] e_arch;
    logic [xlen-1:0]       e_val;
    int errors = 0;
    int checked = 0;
    int blocked_accepts = 0;
    int stall_cycles = 0;
    int low_left = 0;

    int_exec_cluster uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // Instruction words and the RV32I reference.
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic rv_instr_u r_type(input logic [6:0] f7, input logic [2:0] f3);
        rv_instr_u w;
        w          = '0;
        w.r.funct7 = f7;
        w.r.rs2    = 5'd2;
        w.r.rs1    = 5'd1;
        w.r.funct3 = f3;
        w.r.opcode = opc_op;
        return w;
    endfunction

    function automatic rv_instr_u i_type(input logic [11:0] imm, input logic [2:0] f3);
        rv_instr_u w;
        w          = '0;
        w.i.imm12  = imm;
        w.i.rs1    = 5'd1;
        w.i.funct3 = f3;
        w.i.opcode = opc_op_imm;
        return w;
    endfunction

    function automatic rv_instr_u u_type(input logic [6:0] opc, input logic [19:0] imm);
        rv_instr_u w;
        w          = '0;
        w.u.imm20  = imm;
        w.u.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] ref_result(input rv_instr_u w, input logic [31:0] pc,
                                               input logic [31:0] rs1, input logic [31:0] rs2);
        logic [31:0] imm;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        alt;
        imm = {{20{w.i.imm12[11]}}, w.i.imm12};
        if (w.r.opcode == opc_lui) return {w.u.imm20, 12'b0};
        if (w.r.opcode == opc_auipc) return pc + {w.u.imm20, 12'b0};
        b   = (w.r.opcode == opc_op) ? rs2 : imm;
        sh  = b[4:0];
        alt = w.r.funct7[5];  // SUB, SRA and SRAI.
        case (w.r.funct3)
            3'b000:  return (w.r.opcode == opc_op && alt) ? rs1 - b : rs1 + b;
            3'b001:  return rs1 << sh;
            3'b010:  return ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (rs1 < b) ? 32'd1 : 32'd0;
            3'b100:  return rs1 ^ b;
            3'b101: begin
                if (alt) return $signed(rs1) >>> sh;  // Sign fill.
                return rs1 >> sh;
            end
            3'b110:  return rs1 | b;
            default: return rs1 & b;
        endcase
    endfunction

    task automatic add_row(input rv_instr_u w, input logic [31:0] rs1, input logic [31:0] rs2,
                           input bit rnd, input int hold);
        w.r.rd = 5'(nrow + 1);
        if (rnd) begin
            rng = xorshift(rng);
            rs1 = rng;
            rng = xorshift(rng);
            rs2 = rng;
        end
        tbl_instr[nrow] = w;
        tbl_pc[nrow]    = 32'h400 + 32'(4 * nrow);
        tbl_rs1[nrow]   = rs1;
        tbl_rs2[nrow]   = rs2;
        tbl_hold[nrow]  = hold;
        tbl_exp[nrow]   = ref_result(w, tbl_pc[nrow], rs1, rs2);
        nrow++;
    endtask

    // One clock; grant follows the current low stretch.
    task automatic next_cycle();
        @(posedge clk);
        #10;
        if (low_left > 0) begin
            cdb_grant = 1'b0;
            low_left--;
        end else begin
            cdb_grant = 1'b1;
        end
    endtask

    // ----------------------------------------------------------------------
    // Monitor and scoreboard.
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        if (!rst) begin
            if (cdb_grant) blocked_accepts = 0;
            if (disp_valid && !disp_ready) stall_cycles++;
            if (disp_valid && disp_ready) begin
                expq.push_back({disp_rob_id, disp_rd_phy, disp_instr.r.rd, cur_exp});
                if (!cdb_grant) blocked_accepts++;
                assert (blocked_accepts <= fifo_depth + 2) else begin
                    errors++;
                    $display("[FAIL] %0t: %0d accepts while grant low", $time, blocked_accepts);
                end
            end
            if (cdb_valid) begin
                assert (expq.size() != 0) else begin
                    errors++;
                    $display("CDB result at %0t with no pending dispatch", $time);
                end
                if (expq.size() != 0) begin
                    {e_rob, e_phy, e_arch, e_val} = expq.pop_front();
                    checked++;
                    assert (cdb_rob_id == e_rob && cdb_rd_phy == e_phy && cdb_rd_arch == e_arch)
                    else begin
                        errors++;
                        $display("[FAIL] %0t: tags rob %0d phy %0d arch %0d, %s %0d %0d %0d",
                                 $time, cdb_rob_id, cdb_rd_phy, cdb_rd_arch,
                                 "expected rob phy arch", e_rob, e_phy, e_arch);
                    end
                    assert (cdb_value === e_val) else begin
                        errors++;
                        $display("[FAIL] %0t: rob %0d value %h, expected %h",
                                 $time, cdb_rob_id, cdb_value, e_val);
                    end
                end
            end
        end
    end

    initial begin
        repeat (n_rows * 20 + 200) @(posedge clk);
        $display("Timeout: only %0d of %0d results reached the CDB", checked, n_rows);
        $display("tests failed");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Stimulus.
    // ----------------------------------------------------------------------
    initial begin
        rst            = 1'b1;
        disp_valid     = 1'b0;
        disp_instr     = '0;
        disp_pc        = '0;
        disp_rob_id    = '0;
        disp_rd_phy    = '0;
        disp_rs1_value = '0;
        disp_rs2_value = '0;
        cdb_grant      = 1'b0;
        cur_exp        = '0;

        add_row(r_type(7'h00, 3'b000), 0, 0, 1, 0);                      // ADD
        add_row(r_type(7'h20, 3'b000), 0, 1, 0, 0);                      // SUB to -1.
        add_row(r_type(7'h00, 3'b001), 32'h3, 32'hffff_ffff, 0, 0);      // SLL by 31.
        add_row(r_type(7'h00, 3'b010), 32'h8000_0000, 1, 0, 0);
        add_row(r_type(7'h00, 3'b011), 32'h8000_0000, 1, 0, 10);
        add_row(r_type(7'h00, 3'b100), 0, 0, 1, 0);
        add_row(r_type(7'h00, 3'b101), 32'h8000_0000, 31, 0, 0);         // SRL
        add_row(r_type(7'h20, 3'b101), 32'h8000_0000, 31, 0, 0);         // SRA
        add_row(r_type(7'h00, 3'b110), 0, 0, 1, 0);
        add_row(r_type(7'h00, 3'b111), 0, 0, 1, 0);
        add_row(i_type(12'hfff, 3'b000), 0, 0, 0, 0);                    // ADDI -1.
        add_row(i_type(12'hffb, 3'b010), 32'hffff_fffa, 0, 0, 0);
        add_row(i_type(12'hfff, 3'b011), 32'h5, 0, 0, 0);
        add_row(i_type(12'h800, 3'b100), 0, 0, 1, 0);
        add_row(i_type(12'h7ff, 3'b110), 0, 0, 1, 0);
        add_row(i_type(12'hf0f, 3'b111), 0, 0, 1, 0);
        add_row(i_type({7'h00, 5'd31}, 3'b001), 32'h1, 0, 0, 10);
        add_row(i_type({7'h00, 5'd4}, 3'b101), 32'hf000_0000, 0, 0, 0);  // SRLI
        add_row(i_type({7'h20, 5'd4}, 3'b101), 32'hf000_0000, 0, 0, 0);  // SRAI
        add_row(u_type(opc_lui, 20'habcde), 0, 0, 0, 0);
        add_row(u_type(opc_auipc, 20'hfffff), 0, 0, 0, 0);
        add_row(r_type(7'h00, 3'b000), 0, 0, 1, 0);
        add_row(r_type(7'h20, 3'b000), 0, 0, 1, 10);
        add_row(r_type(7'h00, 3'b010), 0, 0, 1, 0);

        repeat (16) @(posedge clk);
        #10;
        rst       = 1'b0;
        cdb_grant = 1'b1;
        @(negedge clk);
        assert (disp_ready && !cdb_valid) else begin
            errors++;
            $display("[FAIL] %0t: cluster not idle after reset", $time);
        end

        for (int k = 0; k < n_rows; k++) begin
            next_cycle();
            disp_valid     = 1'b1;
            disp_instr     = tbl_instr[k];
            disp_pc        = tbl_pc[k];
            disp_rob_id    = rob_id_w'(k);
            disp_rd_phy    = phy_reg_w'(k + 8);
            disp_rs1_value = tbl_rs1[k];
            disp_rs2_value = tbl_rs2[k];
            cur_exp        = tbl_exp[k];
            if (tbl_hold[k] > 0) begin
                cdb_grant = 1'b0;
                low_left  = tbl_hold[k] - 1;
            end
            @(negedge clk);
            while (!disp_ready) begin
                next_cycle();
                @(negedge clk);
            end
        end
        next_cycle();
        disp_valid = 1'b0;

        while (checked < n_rows) next_cycle();
        repeat (4) next_cycle();  // Catch duplicates.

        assert (expq.size() == 0) else begin
            errors++;
            $display("Dispatches still pending at the end of the run");
        end
        assert (stall_cycles > 0) else begin
            errors++;
            $display("disp_ready never went low while grant was held low");
        end

        $display("errors: %0d  results checked: %0d of %0d", errors, checked, n_rows);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/cpu_pkg.sv
src/int_decode_issue.sv
src/fu_alu.sv
src/cdb_result_fifo.sv
src/cdb_broadcast.sv
src/int_exec_cluster.sv
sim/int_exec_cluster_assertions.sv
sim/tb_int_exec_cluster.sv

/* Bender.yml */
package:
  name: int_exec_cluster

sources:
  - src/cpu_pkg.sv
  - src/int_decode_issue.sv
  - src/fu_alu.sv
  - src/cdb_result_fifo.sv
  - src/cdb_broadcast.sv
  - src/int_exec_cluster.sv
  - target: simulation
    files:
      - sim/int_exec_cluster_assertions.sv
      - sim/tb_int_exec_cluster.sv
